// File: verif/i2c_master_ctrl_testdata.txt
# rw rs prescaler state_done_time slave_acks tx_bytes rx_space
# exp_read_strobes exp_write_strobes exp_end (0 stop, 1 repeated start)
0 0 2 3 8 3 4 3 0 0
0 0 1 2 2 5 4 2 0 0
0 1 3 2 4 2 4 2 0 1
0 1 1 4 0 3 4 0 0 1
0 0 2 2 0 2 4 0 0 0
1 0 2 3 1 0 3 0 3 0
1 1 1 2 1 0 1 0 1 1
1 0 4 2 0 0 2 0 0 0
0 0 1 2 5 1 4 1 0 0
1 1 3 3 2 0 4 0 4 1
0 1 2 2 1 4 4 1 0 1

// File: tb.f
hw/i2c_ctrl_pkg.sv
hw/i2c_phase_seq.sv
hw/i2c_cond_timer.sv
hw/i2c_fifo_strobe.sv
hw/i2c_master_ctrl.sv
verif/i2c_master_ctrl_tb.sv

// File: Makefile
# Verilator flow for the I2C master control sequencer

VERILATOR ?= verilator
TOP       ?= i2c_master_ctrl_tb
RTL_TOP   ?= i2c_master_ctrl
FILELIST  ?= tb.f
SEED      ?= 30
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= sim passed

RTL_FILES := $(filter hw/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_FILES) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/i2c_master_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_ctrl_tb;

    import i2c_ctrl_pkg::*;

    parameter int SEED = 30;

    localparam int    MAX_TESTS = 64;
    localparam int    NFIELD    = 10;
    localparam string DATA_FILE = "verif/i2c_master_ctrl_testdata.txt";

    // ------------------------------
    // DUT signals
    // ------------------------------
    logic i2c_core_clock_i;
    logic reset_bit_n_i;
    logic enable_bit_i;
    logic rw_bit_i;
    logic repeat_start_bit_i;
    logic sda_i;
    logic trans_fifo_empty_i;
    logic rev_fifo_full_i;
    cnt_t state_done_time_i;
    cnt_t counter_detect_edge_i;
    cnt_t counter_data_ack_i;
    cnt_t prescaler_i;
    logic start_cnt_o;
    logic write_addr_cnt_o;
    logic write_data_cnt_o;
    logic read_data_cnt_o;
    logic write_ack_cnt_o;
    logic read_ack_cnt_o;
    logic stop_cnt_o;
    logic repeat_start_cnt_o;
    logic scl_en_o;
    logic sda_en_o;
    logic read_fifo_en_o;
    logic write_fifo_en_o;
    cnt_t repeat_start_count_o;

    // test table and bus model state
    int     cfg [MAX_TESTS][NFIELD];   // rw rs ps sdt acks tx rx exp_rd exp_wr exp_end
    int     ntests;
    int     wd_cycles;
    logic   loaded;
    int     errors;
    int     acks_done;
    int     tx_level;
    int     rx_level;
    int     rd_cnt;
    int     wr_cnt;
    int     end_code;
    int     prev_code;
    int     cfg_acks;
    int     cfg_rx;
    logic   force_nack;
    logic   test_done;
    cnt_t   bitcnt;
    integer seed;

    i2c_master_ctrl i_dut (.*);

    initial begin
        i2c_core_clock_i = 1'b0;
        forever #4 i2c_core_clock_i = ~i2c_core_clock_i;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic int phase_code();
        if (start_cnt_o) return 1;
        if (write_addr_cnt_o) return 2;
        if (read_ack_cnt_o) return 3;              // slave ack slot
        if (write_data_cnt_o) return 4;
        if (read_data_cnt_o) return 5;
        if (write_ack_cnt_o) return 6;             // master ack slot
        if (stop_cnt_o) return 7;
        if (repeat_start_cnt_o) return 8;
        return 0;
    endfunction

    function automatic logic legal_step(int p, int c);
        case (p)
            0: return c == 1;
            1: return c == 2;
            2: return c == 3;
            3: return c == 4 || c == 5 || c == 7 || c == 8;
            4: return c == 3;
            5: return c == 6;
            6: return c == 5 || c == 7 || c == 8;
            7: return c == 0;
            8: return c == 2;
            default: return 1'b0;
        endcase
    endfunction

    task automatic flag_error(string msg);
        $display("** Error @ %0t: %s", $time, msg);
        errors++;
    endtask

    // ------------------------------
    // bus model and per-cycle checks
    // ------------------------------
    always @(posedge i2c_core_clock_i) begin
        int   code;
        int   hot;
        logic tick;
        #1;
        tick = (counter_detect_edge_i == prescaler_i);
        code = phase_code();
        hot  = $countones({start_cnt_o, write_addr_cnt_o, write_data_cnt_o, read_data_cnt_o,
                           write_ack_cnt_o, read_ack_cnt_o, stop_cnt_o, repeat_start_cnt_o});
        if (hot > 1)
            flag_error("phase outputs not one-hot");
        if (sda_en_o != (code == 1 || code == 2 || code == 4 || code == 6 || code == 7 ||
                         code == 8))
            flag_error($sformatf("sda_en_o=%0b wrong in phase %0d", sda_en_o, code));
        if (code <= 1 && scl_en_o)
            flag_error("scl_en_o high in idle or start");
        if (code >= 2 && code <= 6 && !scl_en_o)
            flag_error($sformatf("scl_en_o low in phase %0d", code));

        if (code != prev_code) begin
            if (!legal_step(prev_code, code))
                flag_error($sformatf("illegal phase step %0d -> %0d", prev_code, code));
            if (prev_code == 3 && (code == 4 || code == 5) && code != (rw_bit_i ? 5 : 4))
                flag_error("data direction does not follow rw");
            if (code == 2 || code == 4 || code == 5)
                bitcnt = cnt_t'(8);
            else
                bitcnt = BIT_CNT_ACK_SLOT;
            if (code == 3) begin
                sda_i = force_nack || (acks_done >= cfg_acks);   // high is a nack
                acks_done++;
            end
            if ((code == 7 || code == 8) && end_code < 0)
                end_code = code;
            if (code == 8 && repeat_start_count_o != cnt_t'(prescaler_i + 8'd1))
                flag_error($sformatf("repeated start count %0d", repeat_start_count_o));
            if (code == 7)
                enable_bit_i = 1'b0;
            if (code == 2 && prev_code == 8) begin
                force_nack         = 1'b1;             // close with a stop after the retry
                repeat_start_bit_i = 1'b0;
            end
            if (code == 0 && prev_code == 7)
                test_done = 1'b1;
        end else if (tick) begin
            if ((code == 2 || code == 4 || code == 5) && bitcnt > cnt_t'(1))
                bitcnt = cnt_t'(bitcnt - 8'd1);
            else if (code == 6)
                bitcnt = BIT_CNT_MACK_DONE;
        end

        if (read_fifo_en_o) begin
            if (code != 4)
                flag_error("read_fifo_en_o outside write data");
            rd_cnt++;
            tx_level--;
        end
        if (write_fifo_en_o) begin
            if (code != 5)
                flag_error("write_fifo_en_o outside read data");
            wr_cnt++;
            rx_level++;
        end

        trans_fifo_empty_i    = (tx_level <= 0);
        rev_fifo_full_i       = (rx_level >= cfg_rx);
        counter_detect_edge_i = (counter_detect_edge_i >= prescaler_i) ? '0 :
                                cnt_t'(counter_detect_edge_i + 8'd1);
        counter_data_ack_i    = bitcnt;
        prev_code             = code;
    end

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        wait (loaded);
        repeat (wd_cycles) @(posedge i2c_core_clock_i);
        $display("timeout: the run did not finish within %0d clock cycles", wd_cycles);
        $display("sim failed");
        $finish;
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        int    fd;
        int    max_ps;
        int    gap;
        int    failed;
        int    errs_before;
        int    v [NFIELD];
        string line;
        reset_bit_n_i = 1'b0;
        enable_bit_i = 1'b0;
        rw_bit_i = 1'b0;
        repeat_start_bit_i = 1'b0;
        sda_i = 1'b0;
        trans_fifo_empty_i = 1'b1;
        rev_fifo_full_i = 1'b0;
        state_done_time_i = cnt_t'(3);
        counter_detect_edge_i = '0;
        counter_data_ack_i = '0;
        prescaler_i = cnt_t'(1);
        bitcnt = '0;
        loaded = 1'b0;
        errors = 0;
        failed = 0;
        ntests = 0;
        max_ps = 0;
        acks_done = 0;
        tx_level = 0;
        rx_level = 0;
        rd_cnt = 0;
        wr_cnt = 0;
        end_code = -1;
        prev_code = 0;
        cfg_acks = 0;
        cfg_rx = 1;
        force_nack = 1'b0;
        test_done = 1'b0;
        seed = SEED;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test data file %s", DATA_FILE);
        end else begin
            while (!$feof(fd) && ntests < MAX_TESTS) begin
                void'($fgets(line, fd));
                if ($sscanf(line, "%d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2], v[3],
                            v[4], v[5], v[6], v[7], v[8], v[9]) == NFIELD) begin
                    for (int i = 0; i < NFIELD; i++)
                        cfg[ntests][i] = v[i];
                    if (v[2] > max_ps)
                        max_ps = v[2];
                    ntests++;
                end
            end
            $fclose(fd);
        end
        wd_cycles = ntests * (max_ps + 1) * 200 + 100;
        loaded = 1'b1;

        repeat (10) @(posedge i2c_core_clock_i);
        #1 reset_bit_n_i = 1'b1;

        // bus must stay idle while enable is low
        repeat (20) begin
            @(posedge i2c_core_clock_i);
            #1;
            if (phase_code() != 0 || scl_en_o || sda_en_o || read_fifo_en_o ||
                write_fifo_en_o || repeat_start_count_o != '0)
                flag_error("output active while idle");
        end

        for (int t = 0; t < ntests; t++) begin
            errs_before = errors;
            @(posedge i2c_core_clock_i);
            #1;
            rw_bit_i           = cfg[t][0][0];
            repeat_start_bit_i = cfg[t][1][0];
            prescaler_i        = cnt_t'(cfg[t][2]);
            state_done_time_i  = cnt_t'(cfg[t][3]);
            cfg_acks           = cfg[t][4];
            tx_level           = cfg[t][5];
            cfg_rx             = cfg[t][6];
            rx_level           = 0;
            acks_done          = 0;
            rd_cnt             = 0;
            wr_cnt             = 0;
            end_code           = -1;
            force_nack         = 1'b0;
            test_done          = 1'b0;
            enable_bit_i       = 1'b1;
            do begin
                @(posedge i2c_core_clock_i);
                #1;
            end while (!test_done);

            if (rd_cnt != cfg[t][7])
                flag_error($sformatf("test %0d read strobes %0d, expected %0d",
                                     t, rd_cnt, cfg[t][7]));
            if (wr_cnt != cfg[t][8])
                flag_error($sformatf("test %0d write strobes %0d, expected %0d",
                                     t, wr_cnt, cfg[t][8]));
            if (end_code != (cfg[t][9] != 0 ? 8 : 7))
                flag_error($sformatf("test %0d ended in phase %0d", t, end_code));
            if (errors != errs_before)
                failed++;
            $display("test %0d %s rw=%0d rs=%0d rd_strobes=%0d wr_strobes=%0d end=%s", t,
                     (errors == errs_before) ? "ok" : "FAILED", cfg[t][0], cfg[t][1],
                     rd_cnt, wr_cnt, (end_code == 8) ? "rstart" : "stop");

            gap = 2 + int'($unsigned($random(seed)) % 16);
            repeat (gap) @(posedge i2c_core_clock_i);
        end

        $display("tests %0d, failed %0d, errors %0d", ntests, failed, errors);
        if (errors == 0 && ntests > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/i2c_master_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_ctrl (
    input  wire                       i2c_core_clock_i,
    input  wire                       reset_bit_n_i,
    input  wire                       enable_bit_i,
    input  wire                       rw_bit_i,
    input  wire                       repeat_start_bit_i,
    input  wire                       sda_i,
    input  wire                       trans_fifo_empty_i,
    input  wire                       rev_fifo_full_i,
    input  wire i2c_ctrl_pkg::cnt_t   state_done_time_i,
    input  wire i2c_ctrl_pkg::cnt_t   counter_detect_edge_i,  // from clock generator
    input  wire i2c_ctrl_pkg::cnt_t   counter_data_ack_i,     // from datapath
    input  wire i2c_ctrl_pkg::cnt_t   prescaler_i,
    output logic                      start_cnt_o,
    output logic                      write_addr_cnt_o,
    output logic                      write_data_cnt_o,
    output logic                      read_data_cnt_o,
    output logic                      write_ack_cnt_o,
    output logic                      read_ack_cnt_o,
    output logic                      stop_cnt_o,
    output logic                      repeat_start_cnt_o,
    output logic                      scl_en_o,
    output logic                      sda_en_o,
    output logic                      read_fifo_en_o,
    output logic                      write_fifo_en_o,
    output i2c_ctrl_pkg::cnt_t        repeat_start_count_o
);

    import i2c_ctrl_pkg::*;

    i2c_phase_t phase;
    i2c_phase_t phase_next;
    logic       cond_done;
    logic       scl_hold;

    i2c_phase_seq i_phase_seq (
        .i2c_core_clock_i      (i2c_core_clock_i),
        .reset_bit_n_i         (reset_bit_n_i),
        .enable_bit_i          (enable_bit_i),
        .rw_bit_i              (rw_bit_i),
        .repeat_start_bit_i    (repeat_start_bit_i),
        .sda_i                 (sda_i),
        .trans_fifo_empty_i    (trans_fifo_empty_i),
        .rev_fifo_full_i       (rev_fifo_full_i),
        .counter_detect_edge_i (counter_detect_edge_i),
        .counter_data_ack_i    (counter_data_ack_i),
        .prescaler_i           (prescaler_i),
        .cond_done_i           (cond_done),
        .phase_o               (phase),
        .phase_next_o          (phase_next)
    );

    i2c_cond_timer i_cond_timer (
        .i2c_core_clock_i      (i2c_core_clock_i),
        .reset_bit_n_i         (reset_bit_n_i),
        .phase_i               (phase),
        .phase_next_i          (phase_next),
        .enable_bit_i          (enable_bit_i),
        .state_done_time_i     (state_done_time_i),
        .counter_detect_edge_i (counter_detect_edge_i),
        .prescaler_i           (prescaler_i),
        .cond_done_o           (cond_done),
        .scl_hold_o            (scl_hold),
        .repeat_start_count_o  (repeat_start_count_o)
    );

    i2c_fifo_strobe i_fifo_strobe (
        .i2c_core_clock_i      (i2c_core_clock_i),
        .reset_bit_n_i         (reset_bit_n_i),
        .phase_i               (phase),
        .phase_next_i          (phase_next),
        .read_fifo_en_o        (read_fifo_en_o),
        .write_fifo_en_o       (write_fifo_en_o)
    );

    // ------------------------------
    // phase decode
    // ------------------------------
    assign start_cnt_o        = (phase == PH_START);
    assign write_addr_cnt_o   = (phase == PH_ADDR);
    assign write_data_cnt_o   = (phase == PH_WR_DATA);
    assign read_data_cnt_o    = (phase == PH_RD_DATA);
    assign write_ack_cnt_o    = (phase == PH_WR_DATA_ACK);     // master acks a read byte
    assign read_ack_cnt_o     = (phase == PH_ADDR_ACK) || (phase == PH_RD_DATA_ACK);
    assign stop_cnt_o         = (phase == PH_STOP);
    assign repeat_start_cnt_o = (phase == PH_RSTART);

    // master owns sda everywhere except where the slave answers
    assign sda_en_o = (phase == PH_START) || (phase == PH_ADDR) || (phase == PH_WR_DATA) ||
                      (phase == PH_WR_DATA_ACK) || (phase == PH_RSTART) || (phase == PH_STOP);

    assign scl_en_o = (phase != PH_IDLE) && (phase != PH_START) && !scl_hold;

endmodule

`default_nettype wire

// File: hw/i2c_fifo_strobe.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_fifo_strobe (
    input  wire                              i2c_core_clock_i,
    input  wire                              reset_bit_n_i,
    input  wire i2c_ctrl_pkg::i2c_phase_t    phase_i,
    input  wire i2c_ctrl_pkg::i2c_phase_t    phase_next_i,
    output logic                             read_fifo_en_o,    // pop the transmit fifo
    output logic                             write_fifo_en_o    // push the receive fifo
);

    import i2c_ctrl_pkg::*;

    logic rd_armed_q;
    logic wr_armed_q;
    logic wr_byte_end;
    logic rd_byte_end;

    assign wr_byte_end = (phase_i == PH_WR_DATA) && (phase_next_i == PH_RD_DATA_ACK);
    assign rd_byte_end = (phase_i == PH_RD_DATA) && (phase_next_i == PH_WR_DATA_ACK);

    always_ff @(posedge i2c_core_clock_i) begin
        if (!reset_bit_n_i) begin
            read_fifo_en_o  <= 1'b0;
            write_fifo_en_o <= 1'b0;
            rd_armed_q      <= 1'b0;
            wr_armed_q      <= 1'b0;
        end else begin
            read_fifo_en_o  <= wr_byte_end && rd_armed_q;
            write_fifo_en_o <= rd_byte_end && wr_armed_q;

            if (wr_byte_end && rd_armed_q)
                rd_armed_q <= 1'b0;                         // one pop per byte
            else if (phase_next_i == phase_i)
                rd_armed_q <= 1'b1;

            if (rd_byte_end && wr_armed_q)
                wr_armed_q <= 1'b0;
            else if (phase_next_i == phase_i)
                wr_armed_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/i2c_cond_timer.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_cond_timer (
    input  wire                              i2c_core_clock_i,
    input  wire                              reset_bit_n_i,
    input  wire i2c_ctrl_pkg::i2c_phase_t    phase_i,
    input  wire i2c_ctrl_pkg::i2c_phase_t    phase_next_i,
    input  wire                              enable_bit_i,
    input  wire i2c_ctrl_pkg::cnt_t          state_done_time_i,
    input  wire i2c_ctrl_pkg::cnt_t          counter_detect_edge_i,
    input  wire i2c_ctrl_pkg::cnt_t          prescaler_i,
    output logic                             cond_done_o,
    output logic                             scl_hold_o,            // keep scl low for now
    output i2c_ctrl_pkg::cnt_t               repeat_start_count_o
);

    import i2c_ctrl_pkg::*;

    cnt_t ss_cnt_q;                                         // start and stop countdown
    cnt_t rs_cnt_q;                                         // repeated start countdown
    logic bit_tick;

    assign bit_tick = (counter_detect_edge_i == prescaler_i);

    // ------------------------------
    // start / stop counter
    // ------------------------------
    always_ff @(posedge i2c_core_clock_i) begin
        if (!reset_bit_n_i) begin
            ss_cnt_q <= state_done_time_i;
        end else if (phase_i == PH_STOP && phase_next_i == PH_IDLE && enable_bit_i) begin
            ss_cnt_q <= {state_done_time_i[CNT_W-2:0], 1'b0};   // longer bus free time
        end else if (phase_i == PH_IDLE) begin
            if (!enable_bit_i)
                ss_cnt_q <= state_done_time_i;
            else if (ss_cnt_q != '0)
                ss_cnt_q <= ss_cnt_q - 1'b1;                // core cycles, not ticks
            else
                ss_cnt_q <= state_done_time_i;              // leaving for start
        end else if (phase_i == PH_START || phase_i == PH_STOP) begin
            if (bit_tick && ss_cnt_q != '0)
                ss_cnt_q <= ss_cnt_q - 1'b1;
        end else begin
            ss_cnt_q <= state_done_time_i;
        end
    end

    // ------------------------------
    // repeated start counter
    // ------------------------------
    always_ff @(posedge i2c_core_clock_i) begin
        if (!reset_bit_n_i)
            rs_cnt_q <= '0;
        else if (phase_i == PH_RSTART && rs_cnt_q != '0 && bit_tick)
            rs_cnt_q <= rs_cnt_q - 1'b1;
        else if (phase_next_i == PH_RSTART && phase_i != PH_RSTART)
            rs_cnt_q <= prescaler_i + 1'b1;                 // chosen in an ack phase
    end

    always_comb begin
        cond_done_o = 1'b0;
        scl_hold_o  = 1'b0;
        case (phase_i)
            PH_IDLE:   cond_done_o = (ss_cnt_q == '0);
            PH_START:  cond_done_o = (ss_cnt_q <= cnt_t'(1));
            PH_STOP: begin
                cond_done_o = (ss_cnt_q == '0);
                scl_hold_o  = (ss_cnt_q == state_done_time_i);  // before the first tick
            end
            PH_RSTART: begin
                cond_done_o = (rs_cnt_q == '0);
                scl_hold_o  = (rs_cnt_q > prescaler_i);
            end
            default: begin
                cond_done_o = 1'b0;
            end
        endcase
    end

    assign repeat_start_count_o = rs_cnt_q;

endmodule

`default_nettype wire

// File: hw/i2c_phase_seq.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_phase_seq (
    input  wire                       i2c_core_clock_i,
    input  wire                       reset_bit_n_i,
    input  wire                       enable_bit_i,         // enable from command register
    input  wire                       rw_bit_i,             // 1 reads from the slave
    input  wire                       repeat_start_bit_i,   // end with repeated start, not stop
    input  wire                       sda_i,                // sampled sda, high is a nack
    input  wire                       trans_fifo_empty_i,
    input  wire                       rev_fifo_full_i,
    input  wire i2c_ctrl_pkg::cnt_t   counter_detect_edge_i,
    input  wire i2c_ctrl_pkg::cnt_t   counter_data_ack_i,   // bit count from datapath
    input  wire i2c_ctrl_pkg::cnt_t   prescaler_i,
    input  wire                       cond_done_i,          // condition timer finished
    output i2c_ctrl_pkg::i2c_phase_t  phase_o,
    output i2c_ctrl_pkg::i2c_phase_t  phase_next_o
);

    import i2c_ctrl_pkg::*;

    i2c_phase_t phase_q;
    i2c_phase_t pend_q;                                     // choice held until the bit tick
    i2c_phase_t pend_d;
    i2c_phase_t end_phase;                                  // where a finished transfer goes
    logic       bit_tick;
    logic       byte_last;
    logic       ack_slot;
    logic       mack_done;

    assign bit_tick  = (counter_detect_edge_i == prescaler_i);
    assign byte_last = (counter_data_ack_i == BIT_CNT_BYTE_LAST);
    assign ack_slot  = (counter_data_ack_i == BIT_CNT_ACK_SLOT);
    assign mack_done = (counter_data_ack_i == BIT_CNT_MACK_DONE);
    assign end_phase = repeat_start_bit_i ? PH_RSTART : PH_STOP;

    // ------------------------------
    // next phase decision
    // ------------------------------
    always_comb begin
        pend_d = pend_q;                                    // keep an earlier choice
        case (phase_q)
            PH_IDLE: begin
                if (enable_bit_i && cond_done_i)
                    pend_d = PH_START;
                else
                    pend_d = PH_IDLE;
            end
            PH_START: begin
                pend_d = cond_done_i ? PH_ADDR : PH_START;
            end
            PH_ADDR: begin
                if (byte_last)
                    pend_d = PH_ADDR_ACK;
            end
            PH_ADDR_ACK: begin
                if (ack_slot) begin
                    if (sda_i)
                        pend_d = end_phase;                 // address not acked
                    else if (rw_bit_i)
                        pend_d = PH_RD_DATA;
                    else
                        pend_d = PH_WR_DATA;
                end
            end
            PH_WR_DATA: begin
                if (byte_last)
                    pend_d = PH_RD_DATA_ACK;
            end
            PH_RD_DATA: begin
                if (byte_last)
                    pend_d = PH_WR_DATA_ACK;
            end
            PH_RD_DATA_ACK: begin
                if (ack_slot) begin
                    if (sda_i || trans_fifo_empty_i)
                        pend_d = end_phase;
                    else
                        pend_d = PH_WR_DATA;
                end
            end
            PH_WR_DATA_ACK: begin
                if (mack_done)
                    pend_d = rev_fifo_full_i ? end_phase : PH_RD_DATA;
            end
            PH_RSTART: begin
                pend_d = cond_done_i ? PH_ADDR : PH_RSTART;
            end
            PH_STOP: begin
                pend_d = cond_done_i ? PH_IDLE : PH_STOP;
            end
            default: begin
                pend_d = PH_IDLE;
            end
        endcase
    end

    // ------------------------------
    // phase register
    // ------------------------------
    always_ff @(posedge i2c_core_clock_i) begin
        if (!reset_bit_n_i) begin
            phase_q <= PH_IDLE;
            pend_q  <= PH_IDLE;
        end else begin
            pend_q <= pend_d;
            case (phase_q)
                PH_IDLE, PH_START, PH_RSTART, PH_STOP: begin
                    phase_q <= pend_d;                      // timer decides, no tick needed
                end
                PH_WR_DATA_ACK: begin
                    if (bit_tick && mack_done)
                        phase_q <= pend_d;
                end
                PH_ADDR, PH_ADDR_ACK, PH_WR_DATA, PH_RD_DATA, PH_RD_DATA_ACK: begin
                    if (bit_tick)
                        phase_q <= pend_q;                  // same phase until a choice is held
                end
                default: begin
                    phase_q <= PH_IDLE;
                end
            endcase
        end
    end

    assign phase_o      = phase_q;
    assign phase_next_o = pend_d;

endmodule

`default_nettype wire

// File: hw/i2c_ctrl_pkg.sv
`default_nettype none

package i2c_ctrl_pkg;

    // ------------------------------
    // bus phases
    // ------------------------------
    typedef enum logic [3:0] {
        PH_IDLE        = 4'd0,              // bus released, waiting for enable
        PH_START       = 4'd1,              // start condition
        PH_ADDR        = 4'd2,              // slave address and rw bit
        PH_ADDR_ACK    = 4'd3,              // slave acks the address
        PH_WR_DATA     = 4'd4,              // master shifts out a byte
        PH_RD_DATA     = 4'd5,              // master shifts in a byte
        PH_WR_DATA_ACK = 4'd6,              // master drives the ack after a read byte
        PH_RD_DATA_ACK = 4'd7,              // master samples the ack after a written byte
        PH_RSTART      = 4'd8,              // repeated start condition
        PH_STOP        = 4'd9               // stop condition
    } i2c_phase_t;

    // ------------------------------
    // counters
    // ------------------------------
    localparam int CNT_W = 8;               // timing counter and prescaler width

    typedef logic [CNT_W-1:0] cnt_t;

    // bit counter values seen from the datapath
    localparam cnt_t BIT_CNT_BYTE_LAST = cnt_t'(1);    // last bit of a byte on the line
    localparam cnt_t BIT_CNT_ACK_SLOT  = cnt_t'(0);    // ack bit on the line
    localparam cnt_t BIT_CNT_MACK_DONE = cnt_t'(9);    // master ack bit finished

endpackage

`default_nettype wire
